//--- project.f
source/rob_pkg.sv
source/rob_alloc.sv
source/rob_resolve.sv
source/rob_entries.sv
source/rob_commit.sv
source/rob_top.sv
dv/tb_rob.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build tb_rob with Verilator, run it and check $(LOG)"
	@echo "  clean  remove the build folder and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_rob -Mdir obj_dir
	./obj_dir/Vtb_rob | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- dv/tb_rob.sv
`default_nettype none

module tb_rob import rob_pkg::*; ();

    // about 450 cycles of stimulus in the worst case of one completion per batch
    localparam int stim_cycles = 450;
    localparam int cycle_limit = 2 * stim_cycles + 200;

    logic                        clk = 1'b0;
    logic                        rst_n;
    logic                        alloc_vld;
    logic [group_w-1:0]          slot_vld;
    logic [group_w-1:0]          brnc_in;
    logic [group_w-1:0]          brnc_pred;
    logic [group_w*cond_w-1:0]   brnc_cond;
    logic [group_w*pc_w-1:0]     rcvr_pc;
    logic [group_w-1:0]          reg_wrt_in;
    logic [group_w*preg_w-1:0]   free_preg_in;
    logic                        mult_done_vld;
    logic [rob_idx_w-1:0]        mult_done_idx;
    logic                        alu1_done_vld;
    logic [rob_idx_w-1:0]        alu1_done_idx;
    logic                        alu2_done_vld;
    logic [rob_idx_w-1:0]        alu2_done_idx;
    logic [rob_idx_w-1:0]        brnc_idx;
    logic [cond_w-1:0]           brnc_cmp_rslt;
    logic [rob_ptr_w-1:0]        next_idx;
    logic                        rob_full;
    logic                        rob_empt;
    logic                        mis_pred;
    logic                        cmt_brnc;
    logic [pc_w-1:0]             rcvr_pc_out;
    logic [cnt_w-1:0]            free_preg_cnt;
    logic [preg_w-1:0]           free_preg_num1;
    logic [preg_w-1:0]           free_preg_num2;
    logic [preg_w-1:0]           free_preg_num3;
    logic [preg_w-1:0]           free_preg_num4;

    // reference state with queues in allocation order
    logic [rob_ptr_w-1:0] model_tail;
    logic [rob_depth-1:0] completed;
    int                   seq_cnt;
    int                   cycle_cnt = 0;
    logic [rob_idx_w-1:0] exp_idx [$];
    logic [preg_w-1:0]    exp_preg [$];
    int                   exp_seq [$];
    logic [rob_idx_w-1:0] pend_idx [$];
    int                   pend_seq [$];

    rob_top dut0 (.*);

    always #2 clk = ~clk;

    task automatic fail_run(string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_preg(string name, logic [preg_w-1:0] got, logic [preg_w-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic check_pc(string name, logic [pc_w-1:0] got, logic [pc_w-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_ptr(string name, logic [rob_ptr_w-1:0] got, logic [rob_ptr_w-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    // returns {taken, mispredicted}
    function automatic logic [1:0] branch_outcome(logic pred, logic [cond_w-1:0] cond,
                                                  logic [cond_w-1:0] rslt);
        logic taken;
        taken = (cond == rslt);
        return {taken, pred != taken};
    endfunction

    task automatic alloc_group(logic [group_w-1:0] vmask, logic [group_w-1:0] rmask, int bslot,
                               logic pred, logic [cond_w-1:0] cond, logic [pc_w-1:0] pc,
                               output logic [rob_ptr_w-1:0] bptr, output int bseq);
        logic [group_w-1:0]        vbits;
        logic [group_w-1:0]        rbits;
        logic [group_w-1:0]        bbits;
        logic [group_w-1:0]        pbits;
        logic [group_w*cond_w-1:0] conds;
        logic [group_w*pc_w-1:0]   pcs;
        logic [group_w*preg_w-1:0] pregs;
        logic [rob_idx_w-1:0]      idx;
        bptr  = '0;
        bseq  = 0;
        vbits = vmask;
        rbits = rmask;
        bbits = '0;
        pbits = '0;
        conds = (group_w*cond_w)'($urandom);
        pcs   = {$urandom, $urandom};
        pregs = (group_w*preg_w)'($urandom);
        @(negedge clk);
        while (rob_full) begin
            @(negedge clk);
        end
        for (int k = 0; k < group_w; k++) begin
            idx = model_tail[rob_idx_w-1:0] + rob_idx_w'(k);
            completed[idx] = 1'b0;
            if (k == bslot) begin
                vbits[k] = 1'b1;
                rbits[k] = 1'b0;
                bbits[k] = 1'b1;
                pbits[k] = pred;
                conds[k*cond_w +: cond_w] = cond;
                pcs[k*pc_w +: pc_w] = pc;
                bptr = model_tail + rob_ptr_w'(k);
                bseq = seq_cnt;
            end else if (vbits[k] && rbits[k]) begin
                exp_idx.push_back(idx);
                exp_preg.push_back(pregs[k*preg_w +: preg_w]);
                exp_seq.push_back(seq_cnt);
                pend_idx.push_back(idx);
                pend_seq.push_back(seq_cnt);
            end
            seq_cnt++;
        end
        @(posedge clk);
        alloc_vld    <= 1'b1;
        slot_vld     <= vbits;
        reg_wrt_in   <= rbits;
        brnc_in      <= bbits;
        brnc_pred    <= pbits;
        brnc_cond    <= conds;
        rcvr_pc      <= pcs;
        free_preg_in <= pregs;
        @(posedge clk);
        alloc_vld  <= 1'b0;
        model_tail = model_tail + rob_ptr_w'(group_w);
        @(negedge clk);
        check_ptr("next_idx", next_idx, model_tail);
    endtask

    // up to three random pending entries on separate ports
    task automatic complete_batch();
        logic [rob_idx_w-1:0] picks [3];
        int                   n;
        int                   j;
        n = 1 + int'($urandom % 3);
        if (n > pend_idx.size()) begin
            n = pend_idx.size();
        end
        for (int i = 0; i < 3; i++) begin
            picks[i] = '0;
        end
        for (int i = 0; i < n; i++) begin
            j = int'($urandom % pend_idx.size());
            picks[i] = pend_idx[j];
            pend_idx.delete(j);
            pend_seq.delete(j);
        end
        @(posedge clk);
        mult_done_vld <= (n > 0);
        mult_done_idx <= picks[0];
        alu1_done_vld <= (n > 1);
        alu1_done_idx <= picks[1];
        alu2_done_vld <= (n > 2);
        alu2_done_idx <= picks[2];
        @(posedge clk);
        mult_done_vld <= 1'b0;
        alu1_done_vld <= 1'b0;
        alu2_done_vld <= 1'b0;
        for (int i = 0; i < n; i++) begin
            completed[picks[i]] = 1'b1;
        end
    endtask

    task automatic resolve_branch(logic [rob_ptr_w-1:0] bptr, int bseq, logic pred,
                                  logic [cond_w-1:0] cond, logic [pc_w-1:0] pc,
                                  logic [cond_w-1:0] rslt);
        logic [1:0] outc;
        outc = branch_outcome(pred, cond, rslt);
        @(posedge clk);
        brnc_idx      <= bptr[rob_idx_w-1:0];
        brnc_cmp_rslt <= rslt;
        @(negedge clk);
        check_bit("mis_pred", mis_pred, outc[0]);
        check_bit("cmt_brnc", cmt_brnc, !outc[0]);
        if (outc[0]) begin
            check_pc("rcvr_pc_out", rcvr_pc_out, pc);
        end
        @(posedge clk);
        brnc_cmp_rslt <= '0;
        if (outc[0]) begin
            // restart at the first entry of the next group
            model_tail = {bptr[rob_ptr_w-1:group_sh] + 1'b1, {group_sh{1'b0}}};
            while (exp_seq.size() > 0 && exp_seq[$] > bseq) begin
                void'(exp_seq.pop_back());
                void'(exp_idx.pop_back());
                void'(exp_preg.pop_back());
            end
            while (pend_seq.size() > 0 && pend_seq[$] > bseq) begin
                void'(pend_seq.pop_back());
                void'(pend_idx.pop_back());
            end
        end
        @(negedge clk);
        check_ptr("next_idx", next_idx, model_tail);
    endtask

    task automatic branch_case(logic want_mis);
        logic [cond_w-1:0]    cond;
        logic [cond_w-1:0]    rslt;
        logic [1:0]           outc;
        logic [pc_w-1:0]      pc;
        logic [rob_ptr_w-1:0] bptr;
        logic [rob_ptr_w-1:0] other_ptr;
        int                   bseq;
        int                   other_seq;
        cond = cond_w'($urandom);
        // zero would mean no resolution
        rslt = cond_w'($urandom % 3 + 1);
        pc   = pc_w'($urandom);
        outc = branch_outcome(1'b0, cond, rslt);
        // slots 2 and 3 and the whole next group are younger than the branch
        alloc_group(4'hf, 4'b1101, 1, outc[1] ^ want_mis, cond, pc, bptr, bseq);
        alloc_group(4'hf, group_w'($urandom), -1, 1'b0, '0, '0, other_ptr, other_seq);
        complete_batch();
        resolve_branch(bptr, bseq, outc[1] ^ want_mis, cond, pc, rslt);
    endtask

    task automatic drain();
        while (pend_idx.size() > 0) begin
            complete_batch();
        end
        @(negedge clk);
        while (!rob_empt) begin
            @(negedge clk);
        end
        if (exp_preg.size() != 0) begin
            fail_run("buffer empty while freed registers are still expected");
        end
    endtask

    // freed registers against the allocation order queue
    always @(negedge clk) begin
        logic [preg_w-1:0] got [group_w];
        got[0] = free_preg_num1;
        got[1] = free_preg_num2;
        got[2] = free_preg_num3;
        got[3] = free_preg_num4;
        if (rst_n) begin
            if (brnc_cmp_rslt == '0) begin
                check_bit("mis_pred", mis_pred, 1'b0);
                check_bit("cmt_brnc", cmt_brnc, 1'b0);
            end
            if (free_preg_cnt > cnt_w'(group_w)) begin
                fail_run("more than four registers freed in one cycle");
            end
            for (int n = 0; n < group_w; n++) begin
                if (n < int'(free_preg_cnt)) begin
                    if (exp_preg.size() == 0) begin
                        fail_run("register freed while none is expected");
                    end
                    if (!completed[exp_idx[0]]) begin
                        fail_run("register freed before its entry completed");
                    end
                    check_preg($sformatf("free_preg_num%0d", n + 1), got[n], exp_preg[0]);
                    exp_idx.delete(0);
                    exp_preg.delete(0);
                    exp_seq.delete(0);
                end else begin
                    check_preg($sformatf("free_preg_num%0d", n + 1), got[n], '0);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            fail_run("run did not finish within the cycle limit");
        end
    end

    initial begin
        logic [rob_ptr_w-1:0] start;
        logic [rob_ptr_w-1:0] bptr;
        int                   bseq;
        void'($urandom(32'h2d6d_db43));
        rst_n         = 1'b0;
        alloc_vld     = 1'b0;
        slot_vld      = '0;
        brnc_in       = '0;
        brnc_pred     = '0;
        brnc_cond     = '0;
        rcvr_pc       = '0;
        reg_wrt_in    = '0;
        free_preg_in  = '0;
        mult_done_vld = 1'b0;
        mult_done_idx = '0;
        alu1_done_vld = 1'b0;
        alu1_done_idx = '0;
        alu2_done_vld = 1'b0;
        alu2_done_idx = '0;
        brnc_idx      = '0;
        brnc_cmp_rslt = '0;
        model_tail    = '0;
        completed     = '0;
        seq_cnt       = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        check_bit("rob_empt", rob_empt, 1'b1);
        check_bit("rob_full", rob_full, 1'b0);
        check_ptr("next_idx", next_idx, '0);
        check_bit("free_preg_cnt zero", free_preg_cnt == '0, 1'b1);

        // random masks with completions interleaved
        for (int g = 0; g < 12; g++) begin
            alloc_group(group_w'($urandom), group_w'($urandom), -1, 1'b0, '0, '0, bptr, bseq);
            repeat ($urandom % 3) complete_batch();
        end
        drain();

        // one full lap with nothing completed
        start = model_tail;
        for (int g = 0; g < 16; g++) begin
            alloc_group(4'hf, 4'hf, -1, 1'b0, '0, '0, bptr, bseq);
            check_bit("rob_full", rob_full, g == 15);
            check_bit("rob_empt", rob_empt, 1'b0);
        end
        check_ptr("next_idx", next_idx, start ^ rob_ptr_w'(rob_depth));
        drain();

        branch_case(1'b0);
        drain();
        branch_case(1'b1);
        drain();
        // allocation restarts at the rolled back tail
        alloc_group(4'hf, group_w'($urandom), -1, 1'b0, '0, '0, bptr, bseq);
        drain();

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/rob_top.sv
`default_nettype none

module rob_top import rob_pkg::*; (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    // allocation group
    input  wire logic                        alloc_vld,
    input  wire logic [group_w-1:0]          slot_vld,
    input  wire logic [group_w-1:0]          brnc_in,
    input  wire logic [group_w-1:0]          brnc_pred,
    input  wire logic [group_w*cond_w-1:0]   brnc_cond,
    input  wire logic [group_w*pc_w-1:0]     rcvr_pc,
    input  wire logic [group_w-1:0]          reg_wrt_in,
    input  wire logic [group_w*preg_w-1:0]   free_preg_in,
    // functional unit completion
    input  wire logic                        mult_done_vld,
    input  wire logic [rob_idx_w-1:0]        mult_done_idx,
    input  wire logic                        alu1_done_vld,
    input  wire logic [rob_idx_w-1:0]        alu1_done_idx,
    input  wire logic                        alu2_done_vld,
    input  wire logic [rob_idx_w-1:0]        alu2_done_idx,
    // register file compare
    input  wire logic [rob_idx_w-1:0]        brnc_idx,
    input  wire logic [cond_w-1:0]           brnc_cmp_rslt,
    output logic [rob_ptr_w-1:0]             next_idx,
    output logic                             rob_full,
    output logic                             rob_empt,
    output logic                             mis_pred,
    output logic                             cmt_brnc,
    output logic [pc_w-1:0]                  rcvr_pc_out,
    output logic [cnt_w-1:0]                 free_preg_cnt,
    output logic [preg_w-1:0]                free_preg_num1,
    output logic [preg_w-1:0]                free_preg_num2,
    output logic [preg_w-1:0]                free_preg_num3,
    output logic [preg_w-1:0]                free_preg_num4
);

    logic [rob_ptr_w-1:0]       tail;
    logic [rob_ptr_w-1:0]       head;
    logic                       alloc_we;
    logic [group_w-1:0]         alloc_vld_bits;
    logic [group_w-1:0]         alloc_done_bits;
    logic [group_w-1:0]         alloc_brnc_bits;
    logic [group_w-1:0]         alloc_reg_bits;
    rob_payload_u [group_w-1:0] alloc_payload;
    logic [rob_depth-1:0]       done_set;
    logic [rob_idx_w-1:0]       rollback_tail;
    logic                       brnc_entry_is_brnc;
    rob_payload_u               brnc_entry_payload;
    logic [group_w-1:0]         head_vld;
    logic [group_w-1:0]         head_done;
    logic [group_w-1:0]         head_reg;
    rob_payload_u [group_w-1:0] head_payload;
    logic [cnt_w-1:0]           commit_cnt;

    // tail with its wrap bit goes back to allocation
    assign next_idx = tail;

    rob_alloc u_alloc (
        .clk, .rst_n, .alloc_vld, .slot_vld, .brnc_in, .brnc_pred, .brnc_cond,
        .rcvr_pc, .reg_wrt_in, .free_preg_in, .mis_pred, .rollback_tail, .head,
        .tail, .alloc_we, .alloc_vld_bits, .alloc_done_bits, .alloc_brnc_bits,
        .alloc_reg_bits, .alloc_payload, .rob_full, .rob_empt
    );

    rob_resolve u_resolve (
        .clk, .rst_n, .mult_done_vld, .mult_done_idx, .alu1_done_vld, .alu1_done_idx,
        .alu2_done_vld, .alu2_done_idx, .brnc_idx, .brnc_cmp_rslt,
        .brnc_entry_is_brnc, .brnc_entry_payload, .done_set, .mis_pred, .cmt_brnc,
        .rcvr_pc_out, .rollback_tail
    );

    rob_entries u_entries (
        .clk, .rst_n, .alloc_we, .tail, .alloc_vld_bits, .alloc_done_bits,
        .alloc_brnc_bits, .alloc_reg_bits, .alloc_payload, .done_set, .mis_pred,
        .brnc_idx, .commit_cnt, .head, .brnc_entry_is_brnc, .brnc_entry_payload,
        .head_vld, .head_done, .head_reg, .head_payload
    );

    rob_commit u_commit (
        .clk, .rst_n, .head_vld, .head_done, .head_reg, .head_payload, .tail,
        .mis_pred, .brnc_idx, .head, .commit_cnt, .free_preg_cnt,
        .free_preg_num1, .free_preg_num2, .free_preg_num3, .free_preg_num4
    );

endmodule

`default_nettype wire

//--- source/rob_commit.sv
`default_nettype none

module rob_commit import rob_pkg::*; (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic [group_w-1:0]            head_vld,
    input  wire logic [group_w-1:0]            head_done,
    input  wire logic [group_w-1:0]            head_reg,
    input  rob_payload_u [group_w-1:0]         head_payload,
    input  wire logic [rob_ptr_w-1:0]          tail,
    input  wire logic                          mis_pred,
    input  wire logic [rob_idx_w-1:0]          brnc_idx,
    output logic [rob_ptr_w-1:0]               head,
    output logic [cnt_w-1:0]                   commit_cnt,
    output logic [cnt_w-1:0]                   free_preg_cnt,
    output logic [preg_w-1:0]                  free_preg_num1,
    output logic [preg_w-1:0]                  free_preg_num2,
    output logic [preg_w-1:0]                  free_preg_num3,
    output logic [preg_w-1:0]                  free_preg_num4
);

    logic [rob_ptr_w-1:0] occupancy;
    logic [group_w-1:0]   retire_ok;
    logic [group_w-1:0]   at_brnc;
    logic                 scan_go;
    logic [cnt_w-1:0]     nfree;
    logic [preg_w-1:0]    preg_out [group_w];

    assign occupancy = tail - head;

    // empty slots and squash holes retire as well
    always_comb begin
        for (int k = 0; k < group_w; k++) begin
            retire_ok[k] = (rob_ptr_w'(k) < occupancy) & (~head_vld[k] | head_done[k]);
            at_brnc[k]   = (head[rob_idx_w-1:0] + rob_idx_w'(k)) == brnc_idx;
        end
    end

    // in order prefix, cut after a mispredicted branch
    always_comb begin
        commit_cnt = '0;
        scan_go    = 1'b1;
        for (int k = 0; k < group_w; k++) begin
            if (scan_go && retire_ok[k]) begin
                commit_cnt = cnt_w'(k + 1);
            end else begin
                scan_go = 1'b0;
            end
            if (mis_pred && at_brnc[k]) begin
                scan_go = 1'b0;
            end
        end
    end

    // pack freed registers in program order
    always_comb begin
        nfree = '0;
        for (int n = 0; n < group_w; n++) begin
            preg_out[n] = '0;
        end
        for (int k = 0; k < group_w; k++) begin
            if (cnt_w'(k) < commit_cnt && head_vld[k] && head_reg[k]) begin
                preg_out[nfree[group_sh-1:0]] = head_payload[k].regs.free_preg;
                nfree = nfree + 1'b1;
            end
        end
    end

    assign free_preg_cnt  = nfree;
    assign free_preg_num1 = preg_out[0];
    assign free_preg_num2 = preg_out[1];
    assign free_preg_num3 = preg_out[2];
    assign free_preg_num4 = preg_out[3];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head <= '0;
        end else begin
            head <= head + rob_ptr_w'(commit_cnt);
        end
    end

    // occupancy stays within one lap of the tail
    a_head_behind_tail: assert property (@(posedge clk) disable iff (!rst_n)
        occupancy <= rob_ptr_w'(rob_depth));

endmodule

`default_nettype wire

//--- source/rob_entries.sv
`default_nettype none

module rob_entries import rob_pkg::*; (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          alloc_we,
    input  wire logic [rob_ptr_w-1:0]          tail,
    input  wire logic [group_w-1:0]            alloc_vld_bits,
    input  wire logic [group_w-1:0]            alloc_done_bits,
    input  wire logic [group_w-1:0]            alloc_brnc_bits,
    input  wire logic [group_w-1:0]            alloc_reg_bits,
    input  rob_payload_u [group_w-1:0]         alloc_payload,
    input  wire logic [rob_depth-1:0]          done_set,
    input  wire logic                          mis_pred,
    input  wire logic [rob_idx_w-1:0]          brnc_idx,
    input  wire logic [cnt_w-1:0]              commit_cnt,
    input  wire logic [rob_ptr_w-1:0]          head,
    output logic                               brnc_entry_is_brnc,
    output rob_payload_u                       brnc_entry_payload,
    output logic [group_w-1:0]                 head_vld,
    output logic [group_w-1:0]                 head_done,
    output logic [group_w-1:0]                 head_reg,
    output rob_payload_u [group_w-1:0]         head_payload
);

    logic [rob_depth-1:0] vld_q;
    logic [rob_depth-1:0] done_q;
    logic [rob_depth-1:0] brnc_q;
    logic [rob_depth-1:0] reg_q;
    rob_payload_u         payload_q [rob_depth];

    logic [rob_idx_w-1:0] slot_idx [group_w];
    logic [rob_idx_w-1:0] win_idx  [group_w];
    logic [rob_depth-1:0] clr_mask;
    logic [rob_idx_w-1:0] sq_span;
    logic [rob_idx_w-1:0] sq_off;
    logic [rob_idx_w-1:0] cm_off;

    // entry numbers of the group slots and of the head window
    always_comb begin
        for (int k = 0; k < group_w; k++) begin
            slot_idx[k] = tail[rob_idx_w-1:0] + rob_idx_w'(k);
            win_idx[k]  = head[rob_idx_w-1:0] + rob_idx_w'(k);
        end
    end

    // squash range after the branch up to the old tail, plus retired entries
    always_comb begin
        clr_mask = '0;
        sq_off   = '0;
        cm_off   = '0;
        sq_span  = tail[rob_idx_w-1:0] - brnc_idx;
        for (int i = 0; i < rob_depth; i++) begin
            sq_off = rob_idx_w'(i) - brnc_idx;
            cm_off = rob_idx_w'(i) - head[rob_idx_w-1:0];
            // a zero span means the buffer wrapped all the way round
            if (mis_pred && sq_off != '0 && (sq_off < sq_span || sq_span == '0)) begin
                clr_mask[i] = 1'b1;
            end
            if (cm_off < rob_idx_w'(commit_cnt)) begin
                clr_mask[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q  <= '0;
            done_q <= '0;
            brnc_q <= '0;
            reg_q  <= '0;
        end else begin
            vld_q  <= vld_q & ~clr_mask;
            done_q <= done_q | done_set;
            // the new group overrides whatever was left in its slots
            if (alloc_we) begin
                for (int k = 0; k < group_w; k++) begin
                    vld_q[slot_idx[k]]  <= alloc_vld_bits[k];
                    done_q[slot_idx[k]] <= alloc_done_bits[k];
                    brnc_q[slot_idx[k]] <= alloc_brnc_bits[k];
                    reg_q[slot_idx[k]]  <= alloc_reg_bits[k];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_we) begin
            for (int k = 0; k < group_w; k++) begin
                payload_q[slot_idx[k]] <= alloc_payload[k];
            end
        end
    end

    // branch read port
    assign brnc_entry_is_brnc = vld_q[brnc_idx] & brnc_q[brnc_idx];
    assign brnc_entry_payload = payload_q[brnc_idx];

    // four oldest entries
    always_comb begin
        for (int k = 0; k < group_w; k++) begin
            head_vld[k]     = vld_q[win_idx[k]];
            head_done[k]    = done_q[win_idx[k]];
            head_reg[k]     = reg_q[win_idx[k]];
            head_payload[k] = payload_q[win_idx[k]];
        end
    end

endmodule

`default_nettype wire

//--- source/rob_resolve.sv
`default_nettype none

module rob_resolve import rob_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  mult_done_vld,
    input  wire logic [rob_idx_w-1:0]  mult_done_idx,
    input  wire logic                  alu1_done_vld,
    input  wire logic [rob_idx_w-1:0]  alu1_done_idx,
    input  wire logic                  alu2_done_vld,
    input  wire logic [rob_idx_w-1:0]  alu2_done_idx,
    input  wire logic [rob_idx_w-1:0]  brnc_idx,
    input  wire logic [cond_w-1:0]     brnc_cmp_rslt,
    input  wire logic                  brnc_entry_is_brnc,
    input  rob_payload_u               brnc_entry_payload,
    output logic [rob_depth-1:0]       done_set,
    output logic                       mis_pred,
    output logic                       cmt_brnc,
    output logic [pc_w-1:0]            rcvr_pc_out,
    output logic [rob_idx_w-1:0]       rollback_tail
);

    logic                            resolved;
    logic                            taken;
    logic [rob_idx_w-group_sh-1:0]   next_group;

    // any nonzero compare result is a resolution
    assign resolved = (brnc_cmp_rslt != '0) & brnc_entry_is_brnc;
    assign taken    = (brnc_entry_payload.brnc.cond == brnc_cmp_rslt);

    assign mis_pred    = resolved & (brnc_entry_payload.brnc.pred != taken);
    assign cmt_brnc    = resolved & (brnc_entry_payload.brnc.pred == taken);
    assign rcvr_pc_out = brnc_entry_payload.brnc.rcvr_pc;

    // first entry of the following group, wraps past 63 naturally
    assign next_group    = brnc_idx[rob_idx_w-1:group_sh] + 1'b1;
    assign rollback_tail = {next_group, {group_sh{1'b0}}};

    always_comb begin
        done_set = '0;
        if (mult_done_vld) begin
            done_set[mult_done_idx] = 1'b1;
        end
        if (alu1_done_vld) begin
            done_set[alu1_done_idx] = 1'b1;
        end
        if (alu2_done_vld) begin
            done_set[alu2_done_idx] = 1'b1;
        end
        // mispredicted or not, the branch is finished
        if (resolved) begin
            done_set[brnc_idx] = 1'b1;
        end
    end

    // the register file only resolves live branches
    a_resolve_brnc: assert property (@(posedge clk) disable iff (!rst_n)
        (brnc_cmp_rslt != '0) |-> brnc_entry_is_brnc);

endmodule

`default_nettype wire

//--- source/rob_alloc.sv
`default_nettype none

module rob_alloc import rob_pkg::*; (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          alloc_vld,
    input  wire logic [group_w-1:0]            slot_vld,
    input  wire logic [group_w-1:0]            brnc_in,
    input  wire logic [group_w-1:0]            brnc_pred,
    input  wire logic [group_w*cond_w-1:0]     brnc_cond,
    input  wire logic [group_w*pc_w-1:0]       rcvr_pc,
    input  wire logic [group_w-1:0]            reg_wrt_in,
    input  wire logic [group_w*preg_w-1:0]     free_preg_in,
    input  wire logic                          mis_pred,
    input  wire logic [rob_idx_w-1:0]          rollback_tail,
    input  wire logic [rob_ptr_w-1:0]          head,
    output logic [rob_ptr_w-1:0]               tail,
    output logic                               alloc_we,
    output logic [group_w-1:0]                 alloc_vld_bits,
    output logic [group_w-1:0]                 alloc_done_bits,
    output logic [group_w-1:0]                 alloc_brnc_bits,
    output logic [group_w-1:0]                 alloc_reg_bits,
    output rob_payload_u [group_w-1:0]         alloc_payload,
    output logic                               rob_full,
    output logic                               rob_empt
);

    logic [rob_ptr_w-1:0] occupancy;
    logic                 rb_wrap;

    // distance including the wrap bit
    assign occupancy = tail - head;
    assign rob_full  = occupancy > rob_ptr_w'(rob_depth - group_w);
    assign rob_empt  = (head == tail);

    // a misprediction drops the allocation of the same cycle
    assign alloc_we = alloc_vld & ~rob_full & ~mis_pred;

    assign alloc_vld_bits  = slot_vld;
    assign alloc_brnc_bits = slot_vld & brnc_in;
    // an entry is either a branch or a register writer
    assign alloc_reg_bits  = slot_vld & reg_wrt_in & ~brnc_in;
    // nothing left to wait for
    assign alloc_done_bits = slot_vld & ~brnc_in & ~reg_wrt_in;

    always_comb begin
        for (int k = 0; k < group_w; k++) begin
            alloc_payload[k] = '0;
            if (brnc_in[k]) begin
                alloc_payload[k].brnc.pred    = brnc_pred[k];
                alloc_payload[k].brnc.cond    = brnc_cond[k*cond_w +: cond_w];
                alloc_payload[k].brnc.rcvr_pc = rcvr_pc[k*pc_w +: pc_w];
            end else begin
                alloc_payload[k].regs.free_preg = free_preg_in[k*preg_w +: preg_w];
            end
        end
    end

    // rollback going back below the tail index crossed entry 63
    assign rb_wrap = tail[rob_ptr_w-1] ^ (rollback_tail > tail[rob_idx_w-1:0]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tail <= '0;
        end else if (mis_pred) begin
            tail <= {rb_wrap, rollback_tail};
        end else if (alloc_we) begin
            tail <= tail + rob_ptr_w'(group_w);
        end
    end

    // front end must stall on rob_full
    a_no_alloc_full: assert property (@(posedge clk) disable iff (!rst_n)
        alloc_vld |-> !rob_full);

endmodule

`default_nettype wire

//--- source/rob_pkg.sv
`default_nettype none

package rob_pkg;

    // buffer geometry
    localparam int rob_depth = 64;
    localparam int rob_idx_w = 6;
    // index plus wrap bit
    localparam int rob_ptr_w = 7;

    // allocation group
    localparam int group_w  = 4;
    localparam int group_sh = $clog2(group_w);
    // counts from 0 to group_w
    localparam int cnt_w    = $clog2(group_w + 1);

    // payload fields
    localparam int preg_w = 6;
    localparam int pc_w   = 16;
    localparam int cond_w = 2;

    localparam int payload_w = 1 + cond_w + pc_w;
    localparam int reg_pad_w = payload_w - preg_w;

    // branch view, read when the entry branch bit is set
    typedef struct packed {
        logic              pred;
        logic [cond_w-1:0] cond;
        logic [pc_w-1:0]   rcvr_pc;
    } rob_brnc_info_t;

    // register view, freed physical register at commit
    typedef struct packed {
        logic [reg_pad_w-1:0] pad;
        logic [preg_w-1:0]    free_preg;
    } rob_reg_info_t;

    typedef union packed {
        rob_brnc_info_t brnc;
        rob_reg_info_t  regs;
    } rob_payload_u;

endpackage

`default_nettype wire
